/* hw/cpu_pkg.sv */
package cpu_pkg;

    // widths that carry a meaning
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] imm12_t;     // si12 of addi.w, ld.w, st.w
    typedef logic [19:0] imm20_t;     // si20 of lu12i.w

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI      // passes src2, already shifted by decode
    } alu_op_t;

    localparam word_t NOP_INST = 32'h0280_0000;   // addi.w r0,r0,0
    localparam word_t RESET_PC = 32'h1c00_0000;

    // 3R format, opcode in inst[31:15]
    localparam logic [16:0] OPC_ADD_W = 17'h00020;
    localparam logic [16:0] OPC_SUB_W = 17'h00022;
    localparam logic [16:0] OPC_SLT   = 17'h00024;
    localparam logic [16:0] OPC_AND   = 17'h00029;
    localparam logic [16:0] OPC_OR    = 17'h0002a;

    // 2RI12 format, opcode in inst[31:22]
    localparam logic [9:0]  OPC_ADDI_W = 10'h00a;
    localparam logic [9:0]  OPC_LD_W   = 10'h0a2;
    localparam logic [9:0]  OPC_ST_W   = 10'h0a6;

    // 1RI20 format, opcode in inst[31:25]
    localparam logic [6:0]  OPC_LU12I_W = 7'h0a;

    // branches, opcode in inst[31:26]
    localparam logic [5:0]  OPC_BEQ = 6'h16;
    localparam logic [5:0]  OPC_BNE = 6'h17;
    localparam logic [5:0]  OPC_B   = 6'h14;

endpackage

/* hw/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  stall,
    input  logic  br_taken,
    input  word_t br_target,
    output logic  inst_sram_en,
    output word_t inst_sram_addr,
    input  word_t inst_sram_rdata,
    output word_t id_pc,
    output word_t id_inst
);

    word_t pc;        // address of the fetch in flight
    word_t next_pc;
    logic  squash;    // decode slot holds no valid fetch

    always_comb begin
        if (stall)
            next_pc = pc;
        else if (br_taken)
            next_pc = br_target;
        else
            next_pc = pc + 32'd4;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc     <= RESET_PC;
            squash <= 1'b1;   // nothing fetched yet
        end else begin
            pc <= next_pc;
            if (!stall)
                squash <= br_taken;   // kill the slot behind a taken branch
        end
    end

    always_ff @(posedge clk) begin
        if (!stall)
            id_pc <= pc;
    end

    assign inst_sram_en   = 1'b1;
    assign inst_sram_addr = stall ? id_pc : pc;   // re-read so rdata stays valid
    assign id_inst        = squash ? NOP_INST : inst_sram_rdata;

endmodule

/* hw/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      stall,
    input  word_t     id_pc,
    input  word_t     id_inst,
    input  word_t     rf_rdata1,
    input  word_t     rf_rdata2,
    output reg_addr_t rf_raddr1,
    output reg_addr_t rf_raddr2,
    output logic      use_src1,
    output logic      use_src2,
    output logic      br_taken,
    output word_t     br_target,
    output word_t     ex_pc,
    output alu_op_t   ex_alu_op,
    output word_t     ex_src1,
    output word_t     ex_src2,
    output word_t     ex_store_data,
    output reg_addr_t ex_rd,
    output logic      ex_rf_we,
    output logic      ex_mem_re,
    output logic      ex_mem_we
);

    reg_addr_t   rd;
    reg_addr_t   rj;
    reg_addr_t   rk;
    imm12_t      si12;
    imm20_t      si20;
    logic [15:0] offs16;
    logic [25:0] offs26;
    logic        is_add, is_sub, is_and, is_or, is_slt;
    logic        is_addi, is_lu12i, is_ld, is_st;
    logic        is_beq, is_bne, is_b;
    logic        is_3r;
    logic        writes_rd;
    logic        src_equal;
    alu_op_t     alu_op;
    word_t       src2;

    assign rd     = id_inst[4:0];
    assign rj     = id_inst[9:5];
    assign rk     = id_inst[14:10];
    assign si12   = id_inst[21:10];
    assign si20   = id_inst[24:5];
    assign offs16 = id_inst[25:10];
    assign offs26 = {id_inst[9:0], id_inst[25:10]};   // high half sits in the low bits

    assign is_add   = id_inst[31:15] == OPC_ADD_W;
    assign is_sub   = id_inst[31:15] == OPC_SUB_W;
    assign is_and   = id_inst[31:15] == OPC_AND;
    assign is_or    = id_inst[31:15] == OPC_OR;
    assign is_slt   = id_inst[31:15] == OPC_SLT;
    assign is_addi  = id_inst[31:22] == OPC_ADDI_W;
    assign is_ld    = id_inst[31:22] == OPC_LD_W;
    assign is_st    = id_inst[31:22] == OPC_ST_W;
    assign is_lu12i = id_inst[31:25] == OPC_LU12I_W;
    assign is_beq   = id_inst[31:26] == OPC_BEQ;
    assign is_bne   = id_inst[31:26] == OPC_BNE;
    assign is_b     = id_inst[31:26] == OPC_B;

    assign is_3r     = is_add | is_sub | is_and | is_or | is_slt;
    assign writes_rd = (is_3r | is_addi | is_lu12i | is_ld) & (rd != '0);

    // beq, bne and st.w read rd as second source
    assign rf_raddr1 = rj;
    assign rf_raddr2 = (is_st | is_beq | is_bne) ? rd : rk;
    assign use_src1  = is_3r | is_addi | is_ld | is_st | is_beq | is_bne;
    assign use_src2  = is_3r | is_st | is_beq | is_bne;

    assign src_equal = rf_rdata1 == rf_rdata2;
    assign br_taken  = !stall & (is_b | (is_beq & src_equal) | (is_bne & !src_equal));
    assign br_target = is_b ? id_pc + {{4{offs26[25]}}, offs26, 2'b00}
                            : id_pc + {{14{offs16[15]}}, offs16, 2'b00};

    always_comb begin
        alu_op = ALU_ADD;   // addi, ld, st and nop add too
        if (is_sub)   alu_op = ALU_SUB;
        if (is_and)   alu_op = ALU_AND;
        if (is_or)    alu_op = ALU_OR;
        if (is_slt)   alu_op = ALU_SLT;
        if (is_lu12i) alu_op = ALU_LUI;
    end

    always_comb begin
        if (is_lu12i)
            src2 = {si20, 12'b0};
        else if (is_addi | is_ld | is_st)
            src2 = {{20{si12[11]}}, si12};
        else
            src2 = rf_rdata2;
    end

    always_ff @(posedge clk) begin
        if (!rst_n || stall) begin   // bubble on stall
            ex_rf_we  <= 1'b0;
            ex_mem_re <= 1'b0;
            ex_mem_we <= 1'b0;
        end else begin
            ex_rf_we  <= writes_rd;
            ex_mem_re <= is_ld;
            ex_mem_we <= is_st;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc         <= id_pc;
        ex_alu_op     <= alu_op;
        ex_src1       <= rf_rdata1;
        ex_src2       <= src2;
        ex_store_data <= rf_rdata2;
        ex_rd         <= rd;
    end

endmodule

/* hw/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit import cpu_pkg::*; (
    input  reg_addr_t rf_raddr1,
    input  reg_addr_t rf_raddr2,
    input  logic      use_src1,
    input  logic      use_src2,
    input  reg_addr_t ex_rd,
    input  logic      ex_rf_we,
    input  reg_addr_t mem_rd,
    input  logic      mem_rf_we,
    input  reg_addr_t wb_rd,
    input  logic      wb_rf_we,
    output logic      stall
);

    logic hit1;
    logic hit2;

    // r0 never carries a dependence
    assign hit1 = use_src1 && rf_raddr1 != '0 &&
                  ((ex_rf_we  && rf_raddr1 == ex_rd)  ||
                   (mem_rf_we && rf_raddr1 == mem_rd) ||
                   (wb_rf_we  && rf_raddr1 == wb_rd));

    assign hit2 = use_src2 && rf_raddr2 != '0 &&
                  ((ex_rf_we  && rf_raddr2 == ex_rd)  ||
                   (mem_rf_we && rf_raddr2 == mem_rd) ||
                   (wb_rf_we  && rf_raddr2 == wb_rd));

    assign stall = hit1 | hit2;

endmodule

/* hw/regfile.sv */
`timescale 1ns/1ps

module regfile import cpu_pkg::*; (
    input  logic      clk,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    output word_t     rdata1,
    output word_t     rdata2,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata
);

    word_t regs [31:1];   // r0 has no storage

    always_ff @(posedge clk) begin
        if (we && waddr != '0)
            regs[waddr] <= wdata;
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* hw/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  word_t     ex_pc,
    input  alu_op_t   ex_alu_op,
    input  word_t     ex_src1,
    input  word_t     ex_src2,
    input  word_t     ex_store_data,
    input  reg_addr_t ex_rd,
    input  logic      ex_rf_we,
    input  logic      ex_mem_re,
    input  logic      ex_mem_we,
    output word_t     mem_pc,
    output word_t     mem_result,
    output word_t     mem_store_data,
    output reg_addr_t mem_rd,
    output logic      mem_rf_we,
    output logic      mem_mem_re,
    output logic      mem_mem_we
);

    word_t alu_result;   // also the address of ld.w and st.w

    always_comb begin
        case (ex_alu_op)
            ALU_ADD: alu_result = ex_src1 + ex_src2;
            ALU_SUB: alu_result = ex_src1 - ex_src2;
            ALU_AND: alu_result = ex_src1 & ex_src2;
            ALU_OR:  alu_result = ex_src1 | ex_src2;
            ALU_SLT: alu_result = {31'b0, $signed(ex_src1) < $signed(ex_src2)};
            ALU_LUI: alu_result = ex_src2;
            default: alu_result = ex_src1 + ex_src2;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_rf_we  <= 1'b0;
            mem_mem_re <= 1'b0;
            mem_mem_we <= 1'b0;
        end else begin
            mem_rf_we  <= ex_rf_we;
            mem_mem_re <= ex_mem_re;
            mem_mem_we <= ex_mem_we;
        end
    end

    always_ff @(posedge clk) begin
        mem_pc         <= ex_pc;
        mem_result     <= alu_result;
        mem_store_data <= ex_store_data;
        mem_rd         <= ex_rd;
    end

endmodule

/* hw/mem_wb_stage.sv */
`timescale 1ns/1ps

module mem_wb_stage import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  word_t      mem_pc,
    input  word_t      mem_result,
    input  word_t      mem_store_data,
    input  reg_addr_t  mem_rd,
    input  logic       mem_rf_we,
    input  logic       mem_mem_re,
    input  logic       mem_mem_we,
    output logic [3:0] data_sram_we,
    output word_t      data_sram_addr,
    output word_t      data_sram_wdata,
    input  word_t      data_sram_rdata,
    output reg_addr_t  wb_rd,
    output logic       wb_rf_we,
    output word_t      wb_wdata,
    output word_t      debug_wb_pc
);

    word_t wb_result;
    logic  wb_load;   // take the word from the sram

    // word accesses only, so all lanes or none
    assign data_sram_we    = {4{mem_mem_we}};
    assign data_sram_addr  = mem_result;
    assign data_sram_wdata = mem_store_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_rf_we <= 1'b0;
            wb_load  <= 1'b0;
        end else begin
            wb_rf_we <= mem_rf_we;
            wb_load  <= mem_mem_re;
        end
    end

    always_ff @(posedge clk) begin
        debug_wb_pc <= mem_pc;
        wb_rd       <= mem_rd;
        wb_result   <= mem_result;
    end

    assign wb_wdata = wb_load ? data_sram_rdata : wb_result;   // rdata lands this cycle

endmodule

/* hw/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    // instruction sram
    output logic      inst_sram_en,
    output word_t     inst_sram_addr,
    input  word_t     inst_sram_rdata,
    // data sram
    output logic [3:0] data_sram_we,
    output word_t     data_sram_addr,
    output word_t     data_sram_wdata,
    input  word_t     data_sram_rdata,
    // trace
    output word_t     debug_wb_pc,
    output logic      debug_wb_rf_we,
    output reg_addr_t debug_wb_rf_wnum,
    output word_t     debug_wb_rf_wdata
);

    logic      stall;
    logic      br_taken;
    word_t     br_target;
    word_t     id_pc;
    word_t     id_inst;

    reg_addr_t rf_raddr1;
    reg_addr_t rf_raddr2;
    word_t     rf_rdata1;
    word_t     rf_rdata2;
    logic      use_src1;
    logic      use_src2;

    word_t     ex_pc;
    alu_op_t   ex_alu_op;
    word_t     ex_src1;
    word_t     ex_src2;
    word_t     ex_store_data;
    reg_addr_t ex_rd;
    logic      ex_rf_we;
    logic      ex_mem_re;
    logic      ex_mem_we;

    word_t     mem_pc;
    word_t     mem_result;
    word_t     mem_store_data;
    reg_addr_t mem_rd;
    logic      mem_rf_we;
    logic      mem_mem_re;
    logic      mem_mem_we;

    fetch_stage u_fetch (
        .clk             (clk),
        .rst_n           (rst_n),
        .stall           (stall),
        .br_taken        (br_taken),
        .br_target       (br_target),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_rdata (inst_sram_rdata),
        .id_pc           (id_pc),
        .id_inst         (id_inst)
    );

    decode_stage u_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .id_pc         (id_pc),
        .id_inst       (id_inst),
        .rf_rdata1     (rf_rdata1),
        .rf_rdata2     (rf_rdata2),
        .rf_raddr1     (rf_raddr1),
        .rf_raddr2     (rf_raddr2),
        .use_src1      (use_src1),
        .use_src2      (use_src2),
        .br_taken      (br_taken),
        .br_target     (br_target),
        .ex_pc         (ex_pc),
        .ex_alu_op     (ex_alu_op),
        .ex_src1       (ex_src1),
        .ex_src2       (ex_src2),
        .ex_store_data (ex_store_data),
        .ex_rd         (ex_rd),
        .ex_rf_we      (ex_rf_we),
        .ex_mem_re     (ex_mem_re),
        .ex_mem_we     (ex_mem_we)
    );

    hazard_unit u_hazard (
        .rf_raddr1 (rf_raddr1),
        .rf_raddr2 (rf_raddr2),
        .use_src1  (use_src1),
        .use_src2  (use_src2),
        .ex_rd     (ex_rd),
        .ex_rf_we  (ex_rf_we),
        .mem_rd    (mem_rd),
        .mem_rf_we (mem_rf_we),
        .wb_rd     (debug_wb_rf_wnum),
        .wb_rf_we  (debug_wb_rf_we),
        .stall     (stall)
    );

    // write port fed straight from the trace signals of writeback
    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (debug_wb_rf_we),
        .waddr  (debug_wb_rf_wnum),
        .wdata  (debug_wb_rf_wdata)
    );

    execute_stage u_execute (
        .clk            (clk),
        .rst_n          (rst_n),
        .ex_pc          (ex_pc),
        .ex_alu_op      (ex_alu_op),
        .ex_src1        (ex_src1),
        .ex_src2        (ex_src2),
        .ex_store_data  (ex_store_data),
        .ex_rd          (ex_rd),
        .ex_rf_we       (ex_rf_we),
        .ex_mem_re      (ex_mem_re),
        .ex_mem_we      (ex_mem_we),
        .mem_pc         (mem_pc),
        .mem_result     (mem_result),
        .mem_store_data (mem_store_data),
        .mem_rd         (mem_rd),
        .mem_rf_we      (mem_rf_we),
        .mem_mem_re     (mem_mem_re),
        .mem_mem_we     (mem_mem_we)
    );

    mem_wb_stage u_mem_wb (
        .clk             (clk),
        .rst_n           (rst_n),
        .mem_pc          (mem_pc),
        .mem_result      (mem_result),
        .mem_store_data  (mem_store_data),
        .mem_rd          (mem_rd),
        .mem_rf_we       (mem_rf_we),
        .mem_mem_re      (mem_mem_re),
        .mem_mem_we      (mem_mem_we),
        .data_sram_we    (data_sram_we),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata),
        .data_sram_rdata (data_sram_rdata),
        .wb_rd           (debug_wb_rf_wnum),
        .wb_rf_we        (debug_wb_rf_we),
        .wb_wdata        (debug_wb_rf_wdata),
        .debug_wb_pc     (debug_wb_pc)
    );

endmodule

/* testbench/cpu_chk.sv */
`timescale 1ns/1ps

module cpu_chk import cpu_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic [3:0] data_sram_we,
    input logic       debug_wb_rf_we,
    input reg_addr_t  debug_wb_rf_wnum
);

    int fail_count = 0;   // summed into the testbench report

    // word stores drive all four lanes or none
    a_whole_word: assert property (@(posedge clk) disable iff (!rst_n)
        data_sram_we == 4'h0 || data_sram_we == 4'hf)
    else begin
        fail_count++;
        $error("data_sram_we is %b", data_sram_we);
    end

    a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
        debug_wb_rf_we |-> debug_wb_rf_wnum != 5'd0)
    else begin
        fail_count++;
        $error("trace reports a write to r0");
    end

    // enables are low in the cycle after a reset edge
    a_quiet_reset: assert property (@(posedge clk)
        !rst_n |=> data_sram_we == 4'h0 && !debug_wb_rf_we)
    else begin
        fail_count++;
        $error("write enable high during reset");
    end

endmodule

bind cpu_top cpu_chk u_chk (
    .clk              (clk),
    .rst_n            (rst_n),
    .data_sram_we     (data_sram_we),
    .debug_wb_rf_we   (debug_wb_rf_we),
    .debug_wb_rf_wnum (debug_wb_rf_wnum)
);

/* testbench/tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu import cpu_pkg::*; ();

    localparam int MEM_WORDS  = 1024;
    localparam int MAX_CYCLES = 4000;

    logic       clk;
    logic       rst_n;
    logic       inst_sram_en;
    word_t      inst_sram_addr;
    word_t      inst_sram_rdata;
    logic [3:0] data_sram_we;
    word_t      data_sram_addr;
    word_t      data_sram_wdata;
    word_t      data_sram_rdata;
    word_t      debug_wb_pc;
    logic       debug_wb_rf_we;
    reg_addr_t  debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;

    word_t     imem [MEM_WORDS];
    word_t     dmem [MEM_WORDS];
    word_t     rng;
    int        prog_len;
    int        value_errors;
    int        other_errors;
    word_t     exp_pc_q [$];        // expected trace in program order
    reg_addr_t exp_rd_q [$];
    word_t     exp_data_q [$];
    word_t     exp_st_addr_q [$];   // expected stores
    word_t     exp_st_data_q [$];

    initial clk = 1'b0;
    always #10 clk = ~clk;

    cpu_top uut (.*);

    // sram models indexed by address bits 11:2
    always @(posedge clk) begin
        if (inst_sram_en)
            inst_sram_rdata <= imem[inst_sram_addr[11:2]];
        if (data_sram_we == 4'hf)
            dmem[data_sram_addr[11:2]] <= data_sram_wdata;
        data_sram_rdata <= dmem[data_sram_addr[11:2]];
    end

    function automatic word_t xorshift32(word_t x);
        word_t s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    function automatic word_t enc_3r(logic [16:0] op, reg_addr_t rd,
                                     reg_addr_t rj, reg_addr_t rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic word_t enc_ri12(logic [9:0] op, reg_addr_t rd,
                                       reg_addr_t rj, imm12_t imm);
        return {op, imm, rj, rd};
    endfunction

    // beq and bne compare rj with rd and jump by whole words
    function automatic word_t enc_br(logic [5:0] op, reg_addr_t rj,
                                     reg_addr_t rd, logic [15:0] offs);
        return {op, offs, rj, rd};
    endfunction

    function automatic void emit(word_t w);
        imem[prog_len] = w;
        prog_len++;
    endfunction

    task automatic check_value(string what, word_t got, word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            value_errors++;
        end
    endtask

    function automatic void build_program();
        // idle words are addi.w r0,r0,index and write nothing
        for (int i = 0; i < MEM_WORDS; i++)
            imem[i] = enc_ri12(OPC_ADDI_W, 5'd0, 5'd0, imm12_t'(i));
        prog_len = 0;
        for (int r = 1; r <= 6; r++) begin
            rng = xorshift32(rng);
            emit({OPC_LU12I_W, rng[31:12], reg_addr_t'(r)});
            emit(enc_ri12(OPC_ADDI_W, reg_addr_t'(r), reg_addr_t'(r), rng[11:0]));
        end
        emit(enc_3r(OPC_ADD_W, 5'd9, 5'd1, 5'd2));
        emit(enc_3r(OPC_SUB_W, 5'd10, 5'd9, 5'd3));      // distance 1
        emit({OPC_LU12I_W, 20'hfffff, 5'd16});
        emit(enc_3r(OPC_AND, 5'd11, 5'd4, 5'd10));       // distance 2
        emit(enc_3r(OPC_ADD_W, 5'd0, 5'd1, 5'd2));       // r0 stays zero
        emit(enc_3r(OPC_OR, 5'd17, 5'd0, 5'd6));
        emit(enc_3r(OPC_OR, 5'd12, 5'd11, 5'd5));        // distance 3
        emit(enc_3r(OPC_SLT, 5'd13, 5'd10, 5'd6));
        emit(enc_3r(OPC_SLT, 5'd14, 5'd6, 5'd10));
        emit(enc_3r(OPC_SLT, 5'd18, 5'd16, 5'd0));       // negative against zero
        emit(enc_ri12(OPC_ADDI_W, 5'd15, 5'd13, 12'h800));
        // store then load the same word at 0x1010
        emit({OPC_LU12I_W, 20'h00001, 5'd20});
        emit(enc_ri12(OPC_ST_W, 5'd12, 5'd20, 12'h010));
        emit(enc_ri12(OPC_LD_W, 5'd21, 5'd20, 12'h010));
        emit(enc_3r(OPC_ADD_W, 5'd22, 5'd21, 5'd1));     // load use
        emit(enc_ri12(OPC_LD_W, 5'd23, 5'd20, 12'hff0));
        emit(enc_ri12(OPC_ST_W, 5'd23, 5'd20, 12'h044));
        // each branch skips one word when taken
        emit(enc_3r(OPC_ADD_W, 5'd24, 5'd3, 5'd0));
        emit(enc_br(OPC_BEQ, 5'd3, 5'd24, 16'd2));       // taken
        emit(enc_ri12(OPC_ADDI_W, 5'd25, 5'd0, 12'h001));
        emit(enc_br(OPC_BEQ, 5'd1, 5'd2, 16'd2));        // not taken
        emit(enc_ri12(OPC_ADDI_W, 5'd25, 5'd0, 12'h002));
        emit(enc_br(OPC_BNE, 5'd1, 5'd2, 16'd2));        // taken
        emit(enc_ri12(OPC_ADDI_W, 5'd26, 5'd0, 12'h003));
        emit(enc_br(OPC_BNE, 5'd3, 5'd24, 16'd2));       // not taken
        emit(enc_ri12(OPC_ADDI_W, 5'd26, 5'd0, 12'h004));
        emit({OPC_B, 16'd2, 10'd0});
        emit(enc_ri12(OPC_ADDI_W, 5'd27, 5'd0, 12'h005));
        // countdown loop closed by a backward bne
        emit(enc_ri12(OPC_ADDI_W, 5'd28, 5'd0, 12'h003));
        emit(enc_ri12(OPC_ADDI_W, 5'd28, 5'd28, 12'hfff));
        emit(enc_br(OPC_BNE, 5'd28, 5'd0, 16'hffff));
        emit(enc_3r(OPC_ADD_W, 5'd29, 5'd28, 5'd9));
        emit({OPC_B, 26'd0});                            // park
    endfunction

    // instruction-level model of the program
    function automatic void run_reference();
        word_t     regs [32];
        word_t     mem [MEM_WORDS];
        word_t     pc;
        word_t     nxt;
        word_t     inst;
        word_t     a;
        word_t     b;
        word_t     d;
        word_t     addr;
        word_t     res;
        logic      wr;
        reg_addr_t rd;
        regs = '{default: '0};
        mem  = dmem;
        pc   = RESET_PC;
        for (int step = 0; step < 2000; step++) begin
            inst = imem[pc[11:2]];
            if (inst == {OPC_B, 26'd0})
                break;
            rd   = inst[4:0];
            a    = regs[inst[9:5]];
            b    = regs[inst[14:10]];
            d    = regs[rd];
            addr = a + {{20{inst[21]}}, inst[21:10]};
            nxt  = pc + 32'd4;
            wr   = 1'b1;
            res  = '0;
            if (inst[31:15] == OPC_ADD_W)        res = a + b;
            else if (inst[31:15] == OPC_SUB_W)   res = a - b;
            else if (inst[31:15] == OPC_AND)     res = a & b;
            else if (inst[31:15] == OPC_OR)      res = a | b;
            else if (inst[31:15] == OPC_SLT)     res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            else if (inst[31:22] == OPC_ADDI_W)  res = addr;
            else if (inst[31:22] == OPC_LD_W)    res = mem[addr[11:2]];
            else if (inst[31:25] == OPC_LU12I_W) res = {inst[24:5], 12'h000};
            else begin
                wr = 1'b0;
                if (inst[31:22] == OPC_ST_W) begin
                    mem[addr[11:2]] = d;
                    exp_st_addr_q.push_back(addr);
                    exp_st_data_q.push_back(d);
                end else if ((inst[31:26] == OPC_BEQ && a == d) ||
                             (inst[31:26] == OPC_BNE && a != d)) begin
                    nxt = pc + {{14{inst[25]}}, inst[25:10], 2'b00};
                end else if (inst[31:26] == OPC_B) begin
                    nxt = pc + {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
                end
            end
            if (wr && rd != 5'd0) begin
                regs[rd] = res;
                exp_pc_q.push_back(pc);
                exp_rd_q.push_back(rd);
                exp_data_q.push_back(res);
            end
            pc = nxt;
        end
    endfunction

    // trace and store ports are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n && debug_wb_rf_we) begin
            if (exp_pc_q.size() == 0) begin
                $display("unexpected register write to r%0d from pc %h at %0t",
                         debug_wb_rf_wnum, debug_wb_pc, $time);
                other_errors++;
            end else begin
                check_value("write pc", debug_wb_pc, exp_pc_q.pop_front());
                check_value("write register", word_t'(debug_wb_rf_wnum),
                            word_t'(exp_rd_q.pop_front()));
                check_value("write data", debug_wb_rf_wdata, exp_data_q.pop_front());
            end
        end
        if (rst_n && data_sram_we != 4'h0) begin
            if (exp_st_addr_q.size() == 0) begin
                $display("unexpected store to %h at %0t", data_sram_addr, $time);
                other_errors++;
            end else begin
                check_value("store address", data_sram_addr, exp_st_addr_q.pop_front());
                check_value("store data", data_sram_wdata, exp_st_data_q.pop_front());
            end
        end
    end

    initial begin
        int cycles;
        rst_n           = 1'b0;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        value_errors    = 0;
        other_errors    = 0;
        rng             = 32'h9e12_152f;
        for (int i = 0; i < MEM_WORDS; i++) begin
            rng     = xorshift32(rng);
            dmem[i] = rng;
        end
        build_program();
        run_reference();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        cycles = 0;
        while ((exp_pc_q.size() != 0 || exp_st_addr_q.size() != 0) && cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_pc_q.size() != 0 || exp_st_addr_q.size() != 0) begin
            $display("timeout: %0d register writes and %0d stores never arrived",
                     exp_pc_q.size(), exp_st_addr_q.size());
            other_errors++;
        end
        $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 value_errors, other_errors, uut.u_chk.fail_count);
        if (value_errors == 0 && other_errors == 0 && uut.u_chk.fail_count == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* files.f */
hw/cpu_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/hazard_unit.sv
hw/regfile.sv
hw/execute_stage.sv
hw/mem_wb_stage.sv
hw/cpu_top.sv
testbench/cpu_chk.sv
testbench/tb_cpu.sv

/* Makefile */
TOP := tb_cpu

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f files.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

lint:
	verilator --lint-only --timing --assert -Wall -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir
